/* verification/psum_reduce_input.txt */
# id op0 op1 op2 leaf0 leaf1 leaf2 leaf3 valid sum (id, leaves, sum in hex)
# node ops: 0 none, 1 add, 2 left, 3 right; op0 is the root
01 1 1 1 0001 0002 0003 0004 1 000a
02 1 1 1 1234 1111 0ff0 0001 1 3336
03 1 1 1 ffff ffff ffff ffff 1 fffc
04 1 1 1 8000 8000 0001 0002 1 0003
05 1 1 1 ffff 0001 0000 0000 1 0000
06 2 3 1 0011 0022 0033 0044 1 0022
07 3 3 1 0011 0022 0033 0044 1 0077
08 2 2 0 aaaa 5555 1234 4321 1 aaaa
09 3 1 2 aaaa 5555 1234 4321 1 1234
0a 3 0 3 aaaa 5555 1234 4321 1 4321
0b 1 2 3 aaaa 5555 1234 4321 1 edcb
0c 1 3 2 fff0 0020 fff0 0030 1 0010
0d 0 1 1 0001 0002 0003 0004 0 0000
0e 1 0 1 0001 0002 0003 0004 0 0000
0f 1 1 0 0001 0002 0003 0004 0 0000
10 2 0 1 0001 0002 0003 0004 0 0000
11 3 1 0 0001 0002 0003 0004 0 0000
12 1 1 1 0100 0200 0300 0400 1 0a00

/* psum_reduce.f */
design/red_types_pkg.sv
design/red_geom_pkg.sv
design/sel_reg_2to1.sv
design/red_node.sv
design/node_cfg.sv
design/reduce_tree.sv
design/psum_reduce.sv
verification/psum_reduce_props.sv
verification/psum_reduce_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
# a $fatal in the run gives a non-zero exit status
verilator --binary --timing --assert --top-module psum_reduce_tb \
	-f psum_reduce.f -o psum_reduce_sim \
	&& ./obj_dir/psum_reduce_sim \
	|| { echo "simulation failed"; exit 1; }

/* verification/psum_reduce_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module psum_reduce_tb;

	import red_types_pkg::*;
	import red_geom_pkg::*;

	localparam int DATA_W      = DEF_DATA_W;
	localparam int NUM_LEAVES  = DEF_NUM_LEAVES;
	localparam int NUM_NODES   = NUM_LEAVES - 1;
	localparam int IDX_W       = $clog2(NUM_LEAVES);
	// one clock per tree level
	localparam int LATENCY     = $clog2(NUM_LEAVES);
	// cycles watched after a vector
	localparam int WAIT_LIMIT  = 8;
	localparam int STREAM_LEN  = 12;
	// ids for tests outside the vector file
	localparam int TEST_NOCFG  = 'h20;
	localparam int TEST_STREAM = 'h21;
	localparam int TEST_RANGE  = 'h22;
	localparam int TEST_RESET  = 'h23;

	logic                         clk;
	logic                         rst;
	logic                         cfg_wr;
	logic [IDX_W-1:0]             cfg_node;
	node_op_t                     cfg_op;
	logic                         valid;
	logic [NUM_LEAVES*DATA_W-1:0] leaf_bus;
	logic                         res_valid;
	logic [DATA_W-1:0]            res_sum;

	// model copy of node config and current leaves
	node_op_t          model_ops [NUM_NODES];
	logic [DATA_W-1:0] leaves [NUM_LEAVES];
	// streamed sums with the oldest first
	logic [DATA_W-1:0] exp_q [$];
	integer            seed = 32'h1c90;

	psum_reduce #(
		.DATA_W     (DATA_W),
		.NUM_LEAVES (NUM_LEAVES)
	) dut (
		.clk        (clk),
		.rst        (rst),
		.i_cfg_wr   (cfg_wr),
		.i_cfg_node (cfg_node),
		.i_cfg_op   (cfg_op),
		.i_valid    (valid),
		.i_leaf_bus (leaf_bus),
		.o_valid    (res_valid),
		.o_sum      (res_sum)
	);

	// 4 ns period
	always #2 clk = ~clk;

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check_value(input int test_id, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("Error: test %0h %s: expected %0h, actual %0h",
				test_id, what, expected, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// one write strobe plus model update for in-range nodes
	task automatic write_cfg(input int node, input node_op_t op);
		@(posedge clk);
		cfg_wr   <= 1'b1;
		cfg_node <= IDX_W'(node);
		cfg_op   <= op;
		if (node < NUM_NODES)
			model_ops[node] = op;
		@(posedge clk);
		cfg_wr <= 1'b0;
	endtask

	// heap walk from the deepest node up with leaves after the nodes
	task automatic compute_expected(output logic exp_v, output logic [DATA_W-1:0] exp_s);
		logic [DATA_W-1:0] val [2*NUM_LEAVES-1];
		logic              vld [2*NUM_LEAVES-1];
		for (int j = 0; j < NUM_LEAVES; j++)
		begin
			val[NUM_NODES+j] = leaves[j];
			vld[NUM_NODES+j] = 1'b1;
		end
		for (int k = NUM_NODES - 1; k >= 0; k--)
		begin
			case (model_ops[k])
				OP_ADD:
				begin
					vld[k] = vld[2*k+1] && vld[2*k+2];
					val[k] = vld[k] ? val[2*k+1] + val[2*k+2] : '0;
				end
				OP_LEFT:
				begin
					vld[k] = vld[2*k+1];
					val[k] = val[2*k+1];
				end
				OP_RIGHT:
				begin
					vld[k] = vld[2*k+2];
					val[k] = val[2*k+2];
				end
				default:
				begin
					vld[k] = 1'b0;
					val[k] = '0;
				end
			endcase
		end
		exp_v = vld[0];
		exp_s = val[0];
	endtask

	// one-cycle strobe that returns on the edge dropping it
	task automatic send_vector();
		@(posedge clk);
		valid <= 1'b1;
		for (int j = 0; j < NUM_LEAVES; j++)
			leaf_bus[j*DATA_W +: DATA_W] <= leaves[j];
		@(posedge clk);
		valid <= 1'b0;
	endtask

	// counts cycles from the strobe to the root result
	task automatic wait_result(input int test_id, output int cycles);
		cycles = 1;
		@(negedge clk);
		while (!res_valid && cycles < WAIT_LIMIT)
		begin
			cycles++;
			@(negedge clk);
		end
		if (!res_valid)
		begin
			$display("Done: errors found");
			$fatal(1, "test %0h timed out waiting for a valid result", test_id);
		end
	endtask

	// nothing may come out over the latency window plus margin
	task automatic watch_idle(input int test_id);
		for (int n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge clk);
			check_value(test_id, "idle valid", 32'(0), 32'(res_valid));
		end
	endtask

	task automatic run_vector(input int test_id);
		logic              model_v;
		logic [DATA_W-1:0] model_s;
		int                lat;
		compute_expected(model_v, model_s);
		send_vector();
		if (model_v)
		begin
			wait_result(test_id, lat);
			check_value(test_id, "latency", 32'(LATENCY), 32'(lat));
			check_value(test_id, "sum", 32'(model_s), 32'(res_sum));
		end
		else
			watch_idle(test_id);
	endtask

	//////////////////////////////
	// test phases
	//////////////////////////////

	task automatic run_file();
		int                fd;
		int                rc;
		int                code;
		int                op0;
		int                op1;
		int                op2;
		int                file_v;
		logic [DATA_W-1:0] file_s;
		logic              model_v;
		logic [DATA_W-1:0] model_s;
		string             line;
		fd = $fopen("verification/psum_reduce_input.txt", "r");
		if (fd == 0)
		begin
			$display("Done: errors found");
			$fatal(1, "cannot open the vector file");
		end
		while (!$feof(fd))
		begin
			rc = $fgets(line, fd);
			// skip comments and blank lines
			if (rc > 0 && line.len() > 1 && line.getc(0) != "#")
			begin
				rc = $sscanf(line, "%h %d %d %d %h %h %h %h %d %h", code, op0, op1, op2,
					leaves[0], leaves[1], leaves[2], leaves[3], file_v, file_s);
				if (rc != 10)
				begin
					$display("Done: errors found");
					$fatal(1, "malformed line in the vector file");
				end
				else
				begin
					write_cfg(0, node_op_t'(op0[1:0]));
					write_cfg(1, node_op_t'(op1[1:0]));
					write_cfg(2, node_op_t'(op2[1:0]));
					// file pair against the model first
					compute_expected(model_v, model_s);
					check_value(code, "model valid", 32'(file_v), 32'(model_v));
					check_value(code, "model sum", 32'(file_s), 32'(model_s));
					run_vector(code);
				end
			end
		end
		$fclose(fd);
	endtask

	// new random vector every cycle with results two cycles behind
	task automatic run_stream();
		logic              model_v;
		logic [DATA_W-1:0] model_s;
		write_cfg(0, OP_ADD);
		write_cfg(1, OP_LEFT);
		write_cfg(2, OP_ADD);
		exp_q.delete();
		for (int c = 0; c < STREAM_LEN + LATENCY + 1; c++)
		begin
			@(posedge clk);
			if (c < STREAM_LEN)
			begin
				for (int j = 0; j < NUM_LEAVES; j++)
				begin
					leaves[j] = DATA_W'($random(seed));
					leaf_bus[j*DATA_W +: DATA_W] <= leaves[j];
				end
				valid <= 1'b1;
				compute_expected(model_v, model_s);
				exp_q.push_back(model_s);
			end
			else
				valid <= 1'b0;
			@(negedge clk);
			if (c >= LATENCY && c < STREAM_LEN + LATENCY)
			begin
				check_value(TEST_STREAM, "stream valid", 32'(1), 32'(res_valid));
				check_value(TEST_STREAM, "stream sum", 32'(exp_q.pop_front()), 32'(res_sum));
			end
			else
				check_value(TEST_STREAM, "stream idle", 32'(0), 32'(res_valid));
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		for (int k = 0; k < NUM_NODES; k++)
			model_ops[k] = OP_NONE;
	endtask

	initial
	begin
		clk      = 1'b0;
		rst      = 1'b1;
		cfg_wr   = 1'b0;
		cfg_node = '0;
		cfg_op   = OP_NONE;
		valid    = 1'b0;
		leaf_bus = '0;
		for (int k = 0; k < NUM_NODES; k++)
			model_ops[k] = OP_NONE;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// no config written yet so every node is idle
		for (int j = 0; j < NUM_LEAVES; j++)
			leaves[j] = DATA_W'(j + 1);
		run_vector(TEST_NOCFG);

		run_file();
		run_stream();

		// write past the last node must not touch the tree
		write_cfg(0, OP_ADD);
		write_cfg(1, OP_ADD);
		write_cfg(2, OP_ADD);
		run_vector(TEST_RANGE);
		write_cfg(NUM_NODES, OP_NONE);
		run_vector(TEST_RANGE);

		// reset clears the config back to idle
		apply_reset();
		run_vector(TEST_RESET);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/psum_reduce_props.sv */
`timescale 1ns/1ns
`default_nettype none

// concurrent checks on the top level, bound into psum_reduce
module psum_reduce_props
#(
	parameter int DATA_W     = red_geom_pkg::DEF_DATA_W,
	parameter int NUM_LEAVES = red_geom_pkg::DEF_NUM_LEAVES
)
(
	input wire                                               clk,
	input wire                                               rst,
	input wire                                               i_valid,
	input wire [(NUM_LEAVES-1)*red_types_pkg::NODE_OP_W-1:0] i_ops,
	input wire                                               i_res_valid,
	input wire [DATA_W-1:0]                                  i_res_sum
);

	import red_types_pkg::*;

	localparam int NUM_NODES = NUM_LEAVES - 1;
	localparam int LEVELS    = $clog2(NUM_LEAVES);

	// high when every node adds
	logic all_add;

	always_comb
	begin
		all_add = 1'b1;
		for (int k = 0; k < NUM_NODES; k++)
			if (i_ops[k*NODE_OP_W +: NODE_OP_W] != OP_ADD)
				all_add = 1'b0;
	end

	//////////////////////////////
	// properties
	//////////////////////////////

	// quiet while in reset
	a_reset_quiet: assert property (@(posedge clk) rst |=> !i_res_valid)
		else $error("o_valid high after a reset cycle");

	// and in the first cycle after it
	a_reset_exit: assert property (@(posedge clk) $fell(rst) |=> !i_res_valid)
		else $error("o_valid high in the first cycle after reset");

	// full add tree, root valid after one cycle per level
	a_add_latency: assert property (@(posedge clk) disable iff (rst)
		(i_valid && all_add) |-> ##LEVELS i_res_valid)
		else $error("no valid result at the expected latency");

	// invalid output carries zero
	a_zero_idle: assert property (@(posedge clk) disable iff (rst)
		!i_res_valid |-> (i_res_sum == '0))
		else $error("o_sum nonzero while o_valid is low");

endmodule

bind psum_reduce psum_reduce_props #(
	.DATA_W      (DATA_W),
	.NUM_LEAVES  (NUM_LEAVES)
) u_props (
	.clk         (clk),
	.rst         (rst),
	.i_valid     (i_valid),
	.i_ops       (ops),
	.i_res_valid (o_valid),
	.i_res_sum   (o_sum)
);

`default_nettype wire

/* design/psum_reduce.sv */
`timescale 1ns/1ns
`default_nettype none

// top: config registers feeding the reduction tree
module psum_reduce
#(
	parameter int DATA_W     = red_geom_pkg::DEF_DATA_W,
	parameter int NUM_LEAVES = red_geom_pkg::DEF_NUM_LEAVES
)
(
	input  wire                              clk,
	input  wire                              rst,
	// config write strobe
	input  wire                              i_cfg_wr,
	input  wire [$clog2(NUM_LEAVES)-1:0]     i_cfg_node,
	input  red_types_pkg::node_op_t          i_cfg_op,
	// leaf vector strobe
	input  wire                              i_valid,
	input  wire [NUM_LEAVES*DATA_W-1:0]      i_leaf_bus,
	// root result, log2(NUM_LEAVES) cycles later
	output logic                             o_valid,
	output logic [DATA_W-1:0]                o_sum
);

	import red_types_pkg::*;

	localparam int NUM_NODES = NUM_LEAVES - 1;

	// flat opcode bus, node k at k*NODE_OP_W
	logic [NUM_NODES*NODE_OP_W-1:0] ops;

	//////////////////////////////
	// config and tree
	//////////////////////////////

	node_cfg #(
		.NUM_LEAVES (NUM_LEAVES)
	) u_cfg (
		.clk        (clk),
		.rst        (rst),
		.i_cfg_wr   (i_cfg_wr),
		.i_cfg_node (i_cfg_node),
		.i_cfg_op   (i_cfg_op),
		.o_ops      (ops)
	);

	reduce_tree #(
		.DATA_W     (DATA_W),
		.NUM_LEAVES (NUM_LEAVES)
	) u_tree (
		.clk        (clk),
		.rst        (rst),
		.i_ops      (ops),
		.i_valid    (i_valid),
		.i_leaf_bus (i_leaf_bus),
		.o_valid    (o_valid),
		.o_sum      (o_sum)
	);

endmodule

`default_nettype wire

/* design/reduce_tree.sv */
`timescale 1ns/1ns
`default_nettype none

// binary tree of red_node, one level per clock
module reduce_tree
#(
	parameter int DATA_W     = 16,
	parameter int NUM_LEAVES = 4
)
(
	input  wire                                           clk,
	input  wire                                           rst,
	input  wire [(NUM_LEAVES-1)*red_types_pkg::NODE_OP_W-1:0] i_ops,
	input  wire                                           i_valid,
	input  wire [NUM_LEAVES*DATA_W-1:0]                   i_leaf_bus,
	output logic                                          o_valid,
	output logic [DATA_W-1:0]                             o_sum
);

	import red_types_pkg::*;

	localparam int NUM_NODES = NUM_LEAVES - 1;
	localparam int LEVELS    = $clog2(NUM_LEAVES);

	// registered node outputs, heap order
	logic [NUM_NODES-1:0] node_valid;
	logic [DATA_W-1:0]    node_data [NUM_NODES];

	//////////////////////////////
	// levels
	//////////////////////////////

	// level lv holds nodes 2**lv-1 .. 2**(lv+1)-2
	for (genvar lv = 0; lv < LEVELS; lv++)
	begin : g_lvl
		for (genvar p = 0; p < (1 << lv); p++)
		begin : g_node
			localparam int K = (1 << lv) - 1 + p;

			logic              l_valid;
			logic              r_valid;
			logic [DATA_W-1:0] l_data;
			logic [DATA_W-1:0] r_data;
			node_op_t          op;

			if (lv == LEVELS - 1)
			begin : g_leaf
				// deepest level, children are leaves 2p and 2p+1
				assign l_valid = i_valid;
				assign r_valid = i_valid;
				assign l_data  = i_leaf_bus[(2*p)*DATA_W +: DATA_W];
				assign r_data  = i_leaf_bus[(2*p+1)*DATA_W +: DATA_W];
			end
			else
			begin : g_inner
				// children 2k+1 and 2k+2, one level down
				assign l_valid = node_valid[2*K+1];
				assign r_valid = node_valid[2*K+2];
				assign l_data  = node_data[2*K+1];
				assign r_data  = node_data[2*K+2];
			end

			assign op = node_op_t'(i_ops[K*NODE_OP_W +: NODE_OP_W]);

			red_node #(
				.DATA_W    (DATA_W)
			) u_node (
				.clk       (clk),
				.rst       (rst),
				.i_op      (op),
				.i_l_valid (l_valid),
				.i_l_data  (l_data),
				.i_r_valid (r_valid),
				.i_r_data  (r_data),
				.o_valid   (node_valid[K]),
				.o_data    (node_data[K])
			);
		end
	end

	// root is the tree result
	assign o_valid = node_valid[0];
	assign o_sum   = node_data[0];

endmodule

`default_nettype wire

/* design/node_cfg.sv */
`timescale 1ns/1ns
`default_nettype none

// per-node operation registers, one write per strobe
module node_cfg
#(
	parameter int NUM_LEAVES = 4
)
(
	input  wire                                           clk,
	input  wire                                           rst,
	input  wire                                           i_cfg_wr,
	input  wire [$clog2(NUM_LEAVES)-1:0]                  i_cfg_node,
	input  red_types_pkg::node_op_t                       i_cfg_op,
	output logic [(NUM_LEAVES-1)*red_types_pkg::NODE_OP_W-1:0] o_ops
);

	import red_types_pkg::*;

	localparam int NUM_NODES = NUM_LEAVES - 1;

	// one opcode per node, heap order
	node_op_t ops_q [NUM_NODES];

	//////////////////////////////
	// write port
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// every node idle
			for (int k = 0; k < NUM_NODES; k++)
				ops_q[k] <= OP_NONE;
		end
		else if (i_cfg_wr && (int'(i_cfg_node) < NUM_NODES))
		begin
			// out of range index simply dropped
			ops_q[i_cfg_node] <= i_cfg_op;
		end
	end

	// flatten, node k at bits k*NODE_OP_W up
	always_comb
	begin
		for (int k = 0; k < NUM_NODES; k++)
			o_ops[k*NODE_OP_W +: NODE_OP_W] = ops_q[k];
	end

endmodule

`default_nettype wire

/* design/red_node.sv */
`timescale 1ns/1ns
`default_nettype none

// one tree node: registered adder or registered pass select
module red_node
#(
	parameter int DATA_W = 16
)
(
	input  wire                      clk,
	input  wire                      rst,
	input  red_types_pkg::node_op_t  i_op,
	input  wire                      i_l_valid,
	input  wire [DATA_W-1:0]         i_l_data,
	input  wire                      i_r_valid,
	input  wire [DATA_W-1:0]         i_r_data,
	output logic                     o_valid,
	output logic [DATA_W-1:0]        o_data
);

	import red_types_pkg::*;

	// adder path registers
	logic              add_valid;
	logic [DATA_W-1:0] add_data;
	// set when the last cycle's op was an add
	logic              was_add;

	// select path
	logic              sel_en;
	logic              sel_cmd;
	logic              sel_in_valid;
	logic              sel_valid;
	logic [DATA_W-1:0] sel_data;

	//////////////////////////////
	// adder path
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			add_valid <= 1'b0;
			was_add   <= 1'b0;
		end
		else
		begin
			add_valid <= i_l_valid && i_r_valid;
			was_add   <= (i_op == OP_ADD);
		end
	end

	// wraps modulo 2**DATA_W, zero unless both children valid
	always_ff @(posedge clk)
	begin
		if (i_l_valid && i_r_valid)
			add_data <= i_l_data + i_r_data;
		else
			add_data <= '0;
	end

	//////////////////////////////
	// pass path
	//////////////////////////////

	// select only runs for the two pass ops, idle otherwise
	assign sel_en       = (i_op == OP_LEFT) || (i_op == OP_RIGHT);
	assign sel_cmd      = (i_op == OP_RIGHT);
	assign sel_in_valid = sel_cmd ? i_r_valid : i_l_valid;

	sel_reg_2to1 #(
		.DATA_W     (DATA_W)
	) u_sel (
		.clk        (clk),
		.rst        (rst),
		.i_en       (sel_en),
		.i_cmd      (sel_cmd),
		.i_valid    (sel_in_valid),
		.i_data_bus ({i_r_data, i_l_data}),
		.o_valid    (sel_valid),
		.o_data_bus (sel_data)
	);

	// output picks whichever path ran last cycle
	assign o_valid = was_add ? add_valid : sel_valid;
	assign o_data  = was_add ? add_data : sel_data;

endmodule

`default_nettype wire

/* design/sel_reg_2to1.sv */
`timescale 1ns/1ns
`default_nettype none

// registered 2:1 select, high half when i_cmd is set
module sel_reg_2to1
#(
	parameter int DATA_W = 16
)
(
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  i_en,
	input  wire                  i_cmd,
	input  wire                  i_valid,
	input  wire [2*DATA_W-1:0]   i_data_bus,
	output logic                 o_valid,
	output logic [DATA_W-1:0]    o_data_bus
);

	//////////////////////////////
	// select register
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		// reset wins over enable
		if (rst || !i_en)
		begin
			o_valid    <= 1'b0;
			o_data_bus <= '0;
		end
		else if (i_valid)
		begin
			o_valid <= 1'b1;
			// 1 takes the right child, 0 the left
			if (i_cmd)
				o_data_bus <= i_data_bus[DATA_W +: DATA_W];
			else
				o_data_bus <= i_data_bus[0 +: DATA_W];
		end
		else
		begin
			// nothing arriving, drop back to idle zero
			o_valid    <= 1'b0;
			o_data_bus <= '0;
		end
	end

endmodule

`default_nettype wire

/* design/red_geom_pkg.sv */
`default_nettype none

package red_geom_pkg;

	//////////////////////////////
	// tree geometry defaults
	//////////////////////////////

	// bits per leaf and per sum, sums wrap at this width
	parameter int DEF_DATA_W = 16;

	// leaves per vector, power of two and at least 2
	parameter int DEF_NUM_LEAVES = 4;

endpackage

`default_nettype wire

/* design/red_types_pkg.sv */
`default_nettype none

package red_types_pkg;

	//////////////////////////////
	// node operations
	//////////////////////////////

	// width of one node opcode on the config bus
	parameter int NODE_OP_W = 2;

	// per-node operation, set at run time
	typedef enum logic [NODE_OP_W-1:0]
	{
		OP_NONE  = 2'd0, // idle, output stays invalid
		OP_ADD   = 2'd1, // sum of both children
		OP_LEFT  = 2'd2, // pass lower-numbered child
		OP_RIGHT = 2'd3  // pass higher-numbered child
	} node_op_t;

endpackage

`default_nettype wire
